//--- common/conv_pkg.sv
package conv_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// data path sizes
	localparam int PIXEL_WIDTH      = 8;
	localparam int WEIGHT_WIDTH     = 8;
	localparam int ACC_WIDTH        = 20;	// holds 9 full-scale products.
	localparam int RESULT_SHIFT     = 4;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// image and window geometry
	localparam int IFM_SIZE         = 6;
	localparam int KERNEL_SIZE      = 3;
	localparam int WINDOW_TAPS      = KERNEL_SIZE * KERNEL_SIZE;
	localparam int BUFFER_DEPTH     = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;
	localparam int COORD_WIDTH      = $clog2(IFM_SIZE);
	localparam int FIRST_SLICE_TAPS = 5;

	// weight port
	localparam int WADDR_WIDTH      = 4;
	localparam int BIAS_ADDR        = 9;

	// output handshake states.
	localparam logic [1:0] OUT_IDLE    = 2'd0;
	localparam logic [1:0] OUT_REQ     = 2'd1;
	localparam logic [1:0] OUT_RELEASE = 2'd2;

endpackage

//--- common/window_if.sv
interface window_if;

	// tap k = kr*KERNEL_SIZE + kc, top-left pixel is tap 0.
	logic [conv_pkg::WINDOW_TAPS-1:0][conv_pkg::PIXEL_WIDTH-1:0]  taps;
	logic [conv_pkg::WINDOW_TAPS-1:0][conv_pkg::WEIGHT_WIDTH-1:0] weights;	// signed per entry.
	logic                                                         window_valid;
	logic                                                         stall;

	modport buffer (
		output taps,
		output window_valid,
		output stall
	);

	modport mac (
		input taps,
		input weights,
		input window_valid,
		input stall
	);

	modport store (
		output weights
	);

endinterface

//--- rtl/window_buffer/window_line_buffer.sv
module window_line_buffer (
	input  logic                             clk,
	input  logic                             reset,
	input  logic                             shift,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0] pixel,
	window_if.buffer                         win
);

	logic [conv_pkg::PIXEL_WIDTH-1:0] shift_reg [conv_pkg::BUFFER_DEPTH];
	logic [conv_pkg::COORD_WIDTH-1:0] col_count;
	logic [conv_pkg::COORD_WIDTH-1:0] row_count;
	logic                             window_valid;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pixel shift register, newest pixel at index 0
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < conv_pkg::BUFFER_DEPTH; i++)
				shift_reg[i] <= '0;
		end
		else if (shift)
		begin
			shift_reg[0] <= pixel;
			for (int i = 1; i < conv_pkg::BUFFER_DEPTH; i++)
				shift_reg[i] <= shift_reg[i-1];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// raster position of the incoming pixel
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			col_count    <= '0;
			row_count    <= '0;
			window_valid <= 1'b0;
		end
		else
		begin
			window_valid <= shift && (row_count >= conv_pkg::KERNEL_SIZE - 1) &&
				(col_count >= conv_pkg::KERNEL_SIZE - 1);
			if (shift)
			begin
				if (col_count == conv_pkg::IFM_SIZE - 1)
				begin
					col_count <= '0;
					if (row_count == conv_pkg::IFM_SIZE - 1)
						row_count <= '0;	// next frame starts directly.
					else
						row_count <= row_count + 1'b1;
				end
				else
					col_count <= col_count + 1'b1;
			end
		end
	end

	for (genvar kr = 0; kr < conv_pkg::KERNEL_SIZE; kr++)
	begin : g_row
		for (genvar kc = 0; kc < conv_pkg::KERNEL_SIZE; kc++)
		begin : g_col
			assign win.taps[kr*conv_pkg::KERNEL_SIZE + kc] =
				shift_reg[(conv_pkg::KERNEL_SIZE-1-kr)*conv_pkg::IFM_SIZE +
				(conv_pkg::KERNEL_SIZE-1-kc)];
		end
	end

	assign win.window_valid = window_valid;
	assign win.stall        = ~window_valid;

endmodule

//--- rtl/pixel_intake.sv
module pixel_intake (
	input  logic clk,
	input  logic reset,
	input  logic in_req,
	output logic in_ack,
	input  logic busy,
	output logic shift
);

	// in_ack doubles as the responder state.
	assign shift = in_req && !in_ack && !busy;	// high for the accepting cycle only.

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			in_ack <= 1'b0;
		else if (shift)
			in_ack <= 1'b1;
		else if (!in_req)
			in_ack <= 1'b0;	// source released, close the handshake.
	end

endmodule

//--- rtl/kernel_weight_store.sv
module kernel_weight_store (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic                                     weight_we,
	input  logic [conv_pkg::WADDR_WIDTH-1:0]         weight_addr,
	input  logic [conv_pkg::WEIGHT_WIDTH-1:0]        weight_data,
	window_if.store                                  win,
	output logic signed [conv_pkg::WEIGHT_WIDTH-1:0] bias
);

	logic [conv_pkg::WINDOW_TAPS-1:0][conv_pkg::WEIGHT_WIDTH-1:0] weight_regs;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			weight_regs <= '0;
			bias        <= '0;
		end
		else if (weight_we)
		begin
			if (weight_addr < conv_pkg::WINDOW_TAPS)
				weight_regs[weight_addr] <= weight_data;
			else if (weight_addr == conv_pkg::BIAS_ADDR)
				bias <= weight_data;
		end
	end

	assign win.weights = weight_regs;

endmodule

//--- rtl/partial_mac.sv
module partial_mac #(
	parameter int FIRST_TAP = 0,
	parameter int NUM_TAPS  = conv_pkg::FIRST_SLICE_TAPS
) (
	input  logic                                  clk,
	input  logic                                  reset,
	window_if.mac                                 win,
	output logic signed [conv_pkg::ACC_WIDTH-1:0] partial_sum,
	output logic                                  partial_valid
);

	logic signed [conv_pkg::ACC_WIDTH-1:0] slice_sum;

	always_comb
	begin
		slice_sum = '0;
		for (int i = 0; i < NUM_TAPS; i++)
			slice_sum = slice_sum + $signed({1'b0, win.taps[FIRST_TAP+i]}) *
				$signed(win.weights[FIRST_TAP+i]);	// pixel is unsigned.
	end

	always_ff @(posedge clk)
	begin
		if (!win.stall)
			partial_sum <= slice_sum;
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			partial_valid <= 1'b0;
		else
			partial_valid <= win.window_valid;
	end

endmodule

//--- rtl/output_stage.sv
module output_stage (
	input  logic                                     clk,
	input  logic                                     reset,
	input  logic signed [conv_pkg::ACC_WIDTH-1:0]    partial_a,
	input  logic signed [conv_pkg::ACC_WIDTH-1:0]    partial_b,
	input  logic                                     valid_a,
	input  logic                                     valid_b,
	input  logic signed [conv_pkg::WEIGHT_WIDTH-1:0] bias,
	output logic                                     out_req,
	input  logic                                     out_ack,
	output logic [conv_pkg::PIXEL_WIDTH-1:0]         out_data,
	output logic                                     busy
);

	logic [1:0]                            state;
	logic signed [conv_pkg::ACC_WIDTH-1:0] full_sum;
	logic signed [conv_pkg::ACC_WIDTH-1:0] biased;
	logic [conv_pkg::PIXEL_WIDTH-1:0]      clamped;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// combine, scale, bias and ReLU clamp
	always_comb
	begin
		full_sum = partial_a + partial_b;
		biased   = (full_sum >>> conv_pkg::RESULT_SHIFT) + bias;
		if (biased[conv_pkg::ACC_WIDTH-1])
			clamped = '0;	// negative.
		else if (|biased[conv_pkg::ACC_WIDTH-2:conv_pkg::PIXEL_WIDTH])
			clamped = '1;	// saturate at 255.
		else
			clamped = biased[conv_pkg::PIXEL_WIDTH-1:0];
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// four-phase output FSM
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state    <= conv_pkg::OUT_IDLE;
			out_data <= '0;
		end
		else
		begin
			case (state)
				conv_pkg::OUT_IDLE:
				begin
					if (valid_a && valid_b)
					begin
						out_data <= clamped;
						state    <= conv_pkg::OUT_REQ;
					end
				end
				conv_pkg::OUT_REQ:
				begin
					if (out_ack)
						state <= conv_pkg::OUT_RELEASE;
				end
				conv_pkg::OUT_RELEASE:
				begin
					if (!out_ack)
						state <= conv_pkg::OUT_IDLE;
				end
				default:
					state <= conv_pkg::OUT_IDLE;
			endcase
		end
	end

	assign out_req = (state == conv_pkg::OUT_REQ);
	assign busy    = valid_a || valid_b || (state != conv_pkg::OUT_IDLE);	// mac stage or held result.

endmodule

//--- rtl/conv_window_top.sv
module conv_window_top (
	input  logic                              clk,
	input  logic                              reset,
	input  logic                              in_req,
	input  logic [conv_pkg::PIXEL_WIDTH-1:0]  in_data,
	output logic                              in_ack,
	output logic                              out_req,
	input  logic                              out_ack,
	output logic [conv_pkg::PIXEL_WIDTH-1:0]  out_data,
	input  logic                              weight_we,
	input  logic [conv_pkg::WADDR_WIDTH-1:0]  weight_addr,
	input  logic [conv_pkg::WEIGHT_WIDTH-1:0] weight_data
);

	logic                                   shift;
	logic                                   busy;
	logic signed [conv_pkg::WEIGHT_WIDTH-1:0] bias;
	logic signed [conv_pkg::ACC_WIDTH-1:0]  partial_a;
	logic signed [conv_pkg::ACC_WIDTH-1:0]  partial_b;
	logic                                   valid_a;
	logic                                   valid_b;

	window_if win ();

	pixel_intake pixel_intake_inst (
		.clk    (clk),
		.reset  (reset),
		.in_req (in_req),
		.in_ack (in_ack),
		.busy   (busy),
		.shift  (shift)
	);

	window_line_buffer window_line_buffer_inst (
		.clk   (clk),
		.reset (reset),
		.shift (shift),
		.pixel (in_data),
		.win   (win)
	);

	kernel_weight_store kernel_weight_store_inst (
		.clk         (clk),
		.reset       (reset),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data),
		.win         (win),
		.bias        (bias)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// two mac slices over taps 0..4 and 5..8
	partial_mac #(
		.FIRST_TAP (0),
		.NUM_TAPS  (conv_pkg::FIRST_SLICE_TAPS)
	) partial_mac_a_inst (
		.clk           (clk),
		.reset         (reset),
		.win           (win),
		.partial_sum   (partial_a),
		.partial_valid (valid_a)
	);

	partial_mac #(
		.FIRST_TAP (conv_pkg::FIRST_SLICE_TAPS),
		.NUM_TAPS  (conv_pkg::WINDOW_TAPS - conv_pkg::FIRST_SLICE_TAPS)
	) partial_mac_b_inst (
		.clk           (clk),
		.reset         (reset),
		.win           (win),
		.partial_sum   (partial_b),
		.partial_valid (valid_b)
	);

	output_stage output_stage_inst (
		.clk       (clk),
		.reset     (reset),
		.partial_a (partial_a),
		.partial_b (partial_b),
		.valid_a   (valid_a),
		.valid_b   (valid_b),
		.bias      (bias),
		.out_req   (out_req),
		.out_ack   (out_ack),
		.out_data  (out_data),
		.busy      (busy)
	);

endmodule

//--- dv/conv_window_checker.sv
module conv_window_checker (
	input logic                             clk,
	input logic                             reset,
	input logic                             in_req,
	input logic                             in_ack,
	input logic                             out_req,
	input logic                             out_ack,
	input logic [conv_pkg::PIXEL_WIDTH-1:0] out_data
);

	timeunit 1ns;
	timeprecision 1ps;

	logic [conv_pkg::PIXEL_WIDTH-1:0] expected_q [$];
	logic [conv_pkg::PIXEL_WIDTH-1:0] expected;
	logic [conv_pkg::PIXEL_WIDTH-1:0] prev_out_data = '0;
	logic                             prev_reset    = 1'b1;
	logic                             prev_in_ack   = 1'b0;
	logic                             prev_out_req  = 1'b0;
	int                               error_count   = 0;
	int                               result_count  = 0;

	task automatic queue_expected(input logic [conv_pkg::PIXEL_WIDTH-1:0] value);
		expected_q.push_back(value);
	endtask

	function automatic int pending_count();
		return expected_q.size();
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sampled just after the rising edge once the registers have settled
	always @(posedge clk)
	begin
		#1;
		if (prev_reset && !reset)
		begin
			if (in_ack !== 1'b0)
			begin
				$display("FAILED in_ack after reset: got %h, expected %h", in_ack, 1'b0);
				error_count++;
			end
			if (out_req !== 1'b0)
			begin
				$display("FAILED out_req after reset: got %h, expected %h", out_req, 1'b0);
				error_count++;
			end
			if (out_data !== '0)
			begin
				$display("FAILED out_data after reset: got %h, expected %h", out_data, 8'h00);
				error_count++;
			end
		end
		else if (!reset)
		begin
			if (in_ack && !prev_in_ack && !in_req)
			begin
				$display("in_ack rose although in_req was low");
				error_count++;
			end
			if (in_ack && !prev_in_ack && prev_out_req && !out_ack)
			begin
				$display("in_ack rose while a result was still waiting for out_ack");
				error_count++;
			end
			if (!in_ack && prev_in_ack && in_req)
			begin
				$display("in_ack fell before in_req was released");
				error_count++;
			end
			if (!out_req && prev_out_req && !out_ack)
			begin
				$display("out_req fell before out_ack was raised");
				error_count++;
			end
			if (out_req && prev_out_req && out_data !== prev_out_data)
			begin
				$display("FAILED out_data changed while out_req high: got %h, was %h",
					out_data, prev_out_data);
				error_count++;
			end
			if (out_req && !prev_out_req)
			begin
				if (expected_q.size() == 0)
				begin
					$display("a result arrived with no expected value left");
					error_count++;
				end
				else
				begin
					expected = expected_q.pop_front();
					if (out_data !== expected)
					begin
						$display("FAILED out_data result %0d: got %h, expected %h",
							result_count, out_data, expected);
						error_count++;
					end
				end
				result_count++;	// raster order across frames.
			end
		end
		prev_reset    = reset;
		prev_in_ack   = in_ack;
		prev_out_req  = out_req;
		prev_out_data = out_data;
	end

endmodule

//--- dv/conv_window_tb.sv
module conv_window_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int WAIT_LIMIT    = 200;	// cycles per handshake phase.
	localparam int MAX_ACK_DELAY = 5;

	logic                              clk;
	logic                              reset;
	logic                              in_req;
	logic [conv_pkg::PIXEL_WIDTH-1:0]  in_data;
	logic                              in_ack;
	logic                              out_req;
	logic                              out_ack;
	logic [conv_pkg::PIXEL_WIDTH-1:0]  out_data;
	logic                              weight_we;
	logic [conv_pkg::WADDR_WIDTH-1:0]  weight_addr;
	logic [conv_pkg::WEIGHT_WIDTH-1:0] weight_data;

	int                                seed;
	int                                tb_errors;
	int                                results_pending;
	bit                                stop_run;
	logic [conv_pkg::PIXEL_WIDTH-1:0]  pixel_q [$];

	conv_window_top conv_window_top_inst (
		.clk         (clk),
		.reset       (reset),
		.in_req      (in_req),
		.in_data     (in_data),
		.in_ack      (in_ack),
		.out_req     (out_req),
		.out_ack     (out_ack),
		.out_data    (out_data),
		.weight_we   (weight_we),
		.weight_addr (weight_addr),
		.weight_data (weight_data)
	);

	conv_window_checker conv_window_checker_inst (
		.clk      (clk),
		.reset    (reset),
		.in_req   (in_req),
		.in_ack   (in_ack),
		.out_req  (out_req),
		.out_ack  (out_ack),
		.out_data (out_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic report_timeout(input string what);
		if (!stop_run)
		begin
			$display("timeout while waiting for %s", what);
			tb_errors++;
			stop_run = 1'b1;
		end
	endtask

	task automatic write_weight(input int addr, input int value);
		weight_we   = 1'b1;
		weight_addr = addr[conv_pkg::WADDR_WIDTH-1:0];
		weight_data = value[conv_pkg::WEIGHT_WIDTH-1:0];
		@(negedge clk);
		weight_we   = 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input and output four-phase drivers
	task automatic send_pixel(input logic [conv_pkg::PIXEL_WIDTH-1:0] value);
		int cycles;
		cycles  = 0;
		in_data = value;
		in_req  = 1'b1;
		while (!in_ack && cycles < WAIT_LIMIT && !stop_run)
		begin
			@(negedge clk);
			cycles++;
		end
		in_req = 1'b0;
		if (!in_ack)
			report_timeout("in_ack to rise");
		else
		begin
			cycles = 0;
			while (in_ack && cycles < WAIT_LIMIT)
			begin
				@(negedge clk);
				cycles++;
			end
			if (in_ack)
				report_timeout("in_ack to fall");
		end
	endtask

	task automatic drive_pixels();
		while (pixel_q.size() > 0 && !stop_run)
			send_pixel(pixel_q.pop_front());
		pixel_q.delete();
	endtask

	task automatic collect_results(input int count);
		int index;
		int cycles;
		int delay;
		for (index = 0; index < count && !stop_run; index++)
		begin
			cycles = 0;
			while (!out_req && cycles < WAIT_LIMIT && !stop_run)
			begin
				@(negedge clk);
				cycles++;
			end
			if (!out_req)
				report_timeout("out_req to rise");
			else
			begin
				delay = ($random(seed) & 32'h7fff_ffff) % (MAX_ACK_DELAY + 1);
				repeat (delay) @(negedge clk);
				out_ack = 1'b1;
				cycles  = 0;
				while (out_req && cycles < WAIT_LIMIT)
				begin
					@(negedge clk);
					cycles++;
				end
				if (out_req)
					report_timeout("out_req to fall");
				out_ack = 1'b0;
			end
		end
	endtask

	task automatic run_frame();
		fork
			drive_pixels();
			collect_results(results_pending);
		join
		results_pending = 0;
	endtask

	// parse one data file line and run any queued frame before a W write
	task automatic handle_line(input string line);
		int count;
		int addr;
		int value;
		int row [6];
		case (line.getc(0))
			"W":
			begin
				count = $sscanf(line, "W %d %d", addr, value);
				if (count != 2)
				begin
					$display("malformed weight line in test data: %s", line);
					tb_errors++;
				end
				else
				begin
					if (pixel_q.size() > 0)
						run_frame();
					write_weight(addr, value);
				end
			end
			"P":
			begin
				count = $sscanf(line, "P %d %d %d %d %d %d",
					row[0], row[1], row[2], row[3], row[4], row[5]);
				if (count != conv_pkg::IFM_SIZE)
				begin
					$display("malformed pixel line in test data: %s", line);
					tb_errors++;
				end
				for (int i = 0; i < count; i++)
					pixel_q.push_back(row[i][conv_pkg::PIXEL_WIDTH-1:0]);
			end
			"E":
			begin
				count = $sscanf(line, "E %d", value);
				if (count != 1)
				begin
					$display("malformed result line in test data: %s", line);
					tb_errors++;
				end
				else
				begin
					conv_window_checker_inst.queue_expected(value[conv_pkg::PIXEL_WIDTH-1:0]);
					results_pending++;
				end
			end
			default:
				;	// comment or blank line.
		endcase
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	initial
	begin
		int    fd;
		int    code;
		string line;

		reset           = 1'b1;
		in_req          = 1'b0;
		in_data         = '0;
		out_ack         = 1'b0;
		weight_we       = 1'b0;
		weight_addr     = '0;
		weight_data     = '0;
		seed            = 37726;
		tb_errors       = 0;
		results_pending = 0;
		stop_run        = 1'b0;

		repeat (8) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);

		fd = $fopen("dv/conv_window_testdata.txt", "r");
		if (fd == 0)
		begin
			$display("could not open dv/conv_window_testdata.txt");
			tb_errors++;
		end
		else
		begin
			while (!$feof(fd) && !stop_run)
			begin
				code = $fgets(line, fd);
				if (code > 0)
					handle_line(line);
			end
			$fclose(fd);
			if (pixel_q.size() > 0 && !stop_run)
				run_frame();
		end

		repeat (10) @(negedge clk);	// let any stray result show up.
		if (conv_window_checker_inst.pending_count() != 0)
		begin
			$display("%0d expected results never arrived",
				conv_window_checker_inst.pending_count());
			tb_errors++;
		end
		if (out_req)
		begin
			$display("an extra result is held on the output");
			tb_errors++;
		end

		$display("error count: checker %0d, testbench %0d, results seen %0d",
			conv_window_checker_inst.error_count, tb_errors,
			conv_window_checker_inst.result_count);
		if (conv_window_checker_inst.error_count == 0 && tb_errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- conv_window.f
common/conv_pkg.sv
common/window_if.sv
rtl/window_buffer/window_line_buffer.sv
rtl/pixel_intake.sv
rtl/kernel_weight_store.sv
rtl/partial_mac.sv
rtl/output_stage.sv
rtl/conv_window_top.sv
dv/conv_window_checker.sv
dv/conv_window_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the conv_window testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
	-Wno-fatal \
	--top-module conv_window_tb \
	-f conv_window.f \
	-o conv_window_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/conv_window_sim)
sim_status=$?
printf '%s\n' "$sim_output"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_output" | grep -qx "NO ERRORS"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- dv/conv_window_testdata.txt
# W <address> <value>: weight or bias write, signed decimal; P <six pixels>: one image row
# E <value>: expected result, raster order; rows and results run when the next W or the end comes
# frame 1, ramp image 12*r + 3*c + 5, weights 1..9 by tap, bias 10
W 0 1
W 1 2
W 2 3
W 3 4
W 4 5
W 5 6
W 6 7
W 7 8
W 8 9
W 9 10
P 5 8 11 14 17 20
P 17 20 23 26 29 32
P 29 32 35 38 41 44
P 41 44 47 50 53 56
P 53 56 59 62 65 68
P 65 68 71 74 77 80
E 80
E 89
E 97
E 106
E 114
E 123
E 131
E 139
E 148
E 156
E 165
E 173
E 182
E 190
E 199
E 207
# frame 2, taps 0, 2 and 8 only, bias 120, results clamp at both ends
W 0 -16
W 1 0
W 2 -8
W 3 0
W 4 0
W 5 0
W 6 0
W 7 0
W 8 24
W 9 120
P 200 10 100 50 0 250
P 30 60 90 120 150 180
P 0 255 20 40 60 80
P 100 100 5 5 200 200
P 255 255 255 0 0 0
P 12 34 56 78 90 111
E 0
E 145
E 110
E 65
E 52
E 7
E 255
E 210
E 255
E 0
E 70
E 40
E 101
E 134
E 150
E 181
